// ==== rtl/axil_pkg.sv ====
package axil_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Read channel payload types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // AXI response codes as carried on RRESP
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

endpackage

// ==== rtl/xbar_cfg_pkg.sv ====
package xbar_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Crossbar size
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 2;

    // One request or grant bit per master
    typedef logic [NUM_MASTERS-1:0] master_mask_t;

    // One-hot slave select, all zero when the address misses the map
    typedef logic [NUM_SLAVES-1:0] slave_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////

    // Slave j owns [SLAVE_BASE[j], SLAVE_BASE[j] + SLAVE_SIZE[j])
    localparam axil_pkg::addr_t SLAVE_BASE [NUM_SLAVES] = '{
        32'h0000_0000,
        32'h0000_1000
    };

    localparam axil_pkg::addr_t SLAVE_SIZE [NUM_SLAVES] = '{
        32'h0000_1000,
        32'h0000_1000
    };

endpackage

// ==== rtl/axil_read_if.sv ====
`timescale 1ns/1ps

interface axil_read_if;

    import axil_pkg::*;

    // Read address channel
    addr_t araddr;
    logic  arvalid;
    logic  arready;

    // Read data channel
    data_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready;

    // Issuer of reads
    modport mst (
        output araddr, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    // Server of reads
    modport slv (
        input  araddr, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

    modport mon (
        input araddr, arvalid, arready, rdata, rresp, rvalid, rready
    );

endinterface

// ==== rtl/axil_master_port.sv ====
`timescale 1ns/1ps

module axil_master_port (
    input  logic                     aclk,
    input  logic                     rst,
    axil_read_if.slv                 up,
    axil_read_if.mst                 down,
    output xbar_cfg_pkg::slave_sel_t target,
    output logic                     request
);

    import axil_pkg::*;
    import xbar_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_R,
        ERR_R
    } state_t;

    state_t state;
    state_t state_next;
    logic   addr_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < NUM_SLAVES; j++) begin
            target[j] = (up.araddr >= SLAVE_BASE[j]) &&
                        (up.araddr < SLAVE_BASE[j] + SLAVE_SIZE[j]);
        end
    end

    assign addr_valid = |target;

    // Only ask for a slave while a fresh read waits in IDLE
    assign request = (state == IDLE) && up.arvalid && addr_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Outstanding read tracking
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (up.arvalid && up.arready) begin
                    state_next = addr_valid ? WAIT_R : ERR_R;
                end
            end
            WAIT_R, ERR_R: begin
                if (up.rvalid && up.rready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Channel steering
    ////////////////////////////////////////////////////////////////////////////

    // AR goes downstream only for mapped addresses; the switch gates it by grant
    assign down.araddr  = up.araddr;
    assign down.arvalid = (state == IDLE) && up.arvalid && addr_valid;
    assign down.rready  = (state == WAIT_R) && up.rready;

    // Unmapped reads are taken at once and answered locally
    assign up.arready = (state == IDLE) && up.arvalid && (addr_valid ? down.arready : 1'b1);

    always_comb begin
        up.rvalid = 1'b0;
        up.rdata  = '0;
        up.rresp  = OKAY;
        case (state)
            WAIT_R: begin
                up.rvalid = down.rvalid;
                up.rdata  = down.rdata;
                up.rresp  = down.rresp;
            end
            ERR_R: begin
                up.rvalid = 1'b1;
                up.rresp  = DECERR;
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/axil_slave_arbiter.sv ====
`timescale 1ns/1ps

module axil_slave_arbiter (
    input  logic                       aclk,
    input  logic                       rst,
    input  xbar_cfg_pkg::master_mask_t requests,
    axil_read_if.mon                   slave,
    output xbar_cfg_pkg::master_mask_t grant
);

    import xbar_cfg_pkg::*;

    master_mask_t pick;
    logic         r_done;
    logic         rearbitrate;

    // Lowest set bit of the request vector, one-hot
    always_comb begin
        pick = '0;
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
            if (requests[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    // End of the read that owns the slave
    assign r_done = slave.rvalid && slave.rready;

    // Free to choose when nobody holds the slave, or as the holder finishes
    assign rearbitrate = (grant == '0) || r_done;

    ////////////////////////////////////////////////////////////////////////////
    // Grant register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            grant <= '0;
        end else if (rearbitrate) begin
            grant <= pick;
        end
    end

endmodule

// ==== rtl/axil_read_switch.sv ====
`timescale 1ns/1ps

module axil_read_switch (
    input  xbar_cfg_pkg::master_mask_t grants [xbar_cfg_pkg::NUM_SLAVES],
    axil_read_if.slv                   masters [xbar_cfg_pkg::NUM_MASTERS],
    axil_read_if.mst                   slaves  [xbar_cfg_pkg::NUM_SLAVES]
);

    import axil_pkg::*;
    import xbar_cfg_pkg::*;

    // Flattened views of the interface arrays
    addr_t mst_araddr  [NUM_MASTERS];
    logic  mst_arvalid [NUM_MASTERS];
    logic  mst_rready  [NUM_MASTERS];
    logic  slv_arready [NUM_SLAVES];
    data_t slv_rdata   [NUM_SLAVES];
    resp_t slv_rresp   [NUM_SLAVES];
    logic  slv_rvalid  [NUM_SLAVES];

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_mst_in
        assign mst_araddr[i]  = masters[i].araddr;
        assign mst_arvalid[i] = masters[i].arvalid;
        assign mst_rready[i]  = masters[i].rready;
    end

    for (genvar j = 0; j < NUM_SLAVES; j++) begin : g_slv_in
        assign slv_arready[j] = slaves[j].arready;
        assign slv_rdata[j]   = slaves[j].rdata;
        assign slv_rresp[j]   = slaves[j].rresp;
        assign slv_rvalid[j]  = slaves[j].rvalid;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Master to slave: AR and RREADY from the granted master
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < NUM_SLAVES; j++) begin : g_to_slave
        always_comb begin
            slaves[j].araddr  = '0;
            slaves[j].arvalid = 1'b0;
            slaves[j].rready  = 1'b0;
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (grants[j][i]) begin
                    slaves[j].araddr  = mst_araddr[i];
                    slaves[j].arvalid = mst_arvalid[i];
                    slaves[j].rready  = mst_rready[i];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slave to master: ARREADY and R from the slave granting this master
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_to_master
        always_comb begin
            masters[i].arready = 1'b0;
            masters[i].rdata   = '0;
            masters[i].rresp   = OKAY;
            masters[i].rvalid  = 1'b0;
            for (int j = 0; j < NUM_SLAVES; j++) begin
                if (grants[j][i]) begin
                    masters[i].arready = slv_arready[j];
                    masters[i].rdata   = slv_rdata[j];
                    masters[i].rresp   = slv_rresp[j];
                    masters[i].rvalid  = slv_rvalid[j];
                end
            end
        end
    end

endmodule

// ==== rtl/axil_read_xbar.sv ====
`timescale 1ns/1ps

module axil_read_xbar (
    input  logic            aclk,
    input  logic            rst,

    // Master side
    input  axil_pkg::addr_t m_araddr  [xbar_cfg_pkg::NUM_MASTERS],
    input  logic            m_arvalid [xbar_cfg_pkg::NUM_MASTERS],
    output logic            m_arready [xbar_cfg_pkg::NUM_MASTERS],
    output axil_pkg::data_t m_rdata   [xbar_cfg_pkg::NUM_MASTERS],
    output axil_pkg::resp_t m_rresp   [xbar_cfg_pkg::NUM_MASTERS],
    output logic            m_rvalid  [xbar_cfg_pkg::NUM_MASTERS],
    input  logic            m_rready  [xbar_cfg_pkg::NUM_MASTERS],

    // Slave side
    output axil_pkg::addr_t s_araddr  [xbar_cfg_pkg::NUM_SLAVES],
    output logic            s_arvalid [xbar_cfg_pkg::NUM_SLAVES],
    input  logic            s_arready [xbar_cfg_pkg::NUM_SLAVES],
    input  axil_pkg::data_t s_rdata   [xbar_cfg_pkg::NUM_SLAVES],
    input  axil_pkg::resp_t s_rresp   [xbar_cfg_pkg::NUM_SLAVES],
    input  logic            s_rvalid  [xbar_cfg_pkg::NUM_SLAVES],
    output logic            s_rready  [xbar_cfg_pkg::NUM_SLAVES]
);

    import xbar_cfg_pkg::*;

    axil_read_if m_bus      [NUM_MASTERS] ();
    axil_read_if routed_bus [NUM_MASTERS] ();
    axil_read_if s_bus      [NUM_SLAVES]  ();

    slave_sel_t   target     [NUM_MASTERS];
    logic         request    [NUM_MASTERS];
    master_mask_t arb_req    [NUM_SLAVES];
    master_mask_t arb_grant  [NUM_SLAVES];

    ////////////////////////////////////////////////////////////////////////////
    // Master ports
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_master
        assign m_bus[i].araddr  = m_araddr[i];
        assign m_bus[i].arvalid = m_arvalid[i];
        assign m_bus[i].rready  = m_rready[i];
        assign m_arready[i]     = m_bus[i].arready;
        assign m_rdata[i]       = m_bus[i].rdata;
        assign m_rresp[i]       = m_bus[i].rresp;
        assign m_rvalid[i]      = m_bus[i].rvalid;

        axil_master_port u_port (
            .aclk    (aclk),
            .rst     (rst),
            .up      (m_bus[i]),
            .down    (routed_bus[i]),
            .target  (target[i]),
            .request (request[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-slave arbitration
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < NUM_SLAVES; j++) begin : g_slave
        assign s_araddr[j]      = s_bus[j].araddr;
        assign s_arvalid[j]     = s_bus[j].arvalid;
        assign s_rready[j]      = s_bus[j].rready;
        assign s_bus[j].arready = s_arready[j];
        assign s_bus[j].rdata   = s_rdata[j];
        assign s_bus[j].rresp   = s_rresp[j];
        assign s_bus[j].rvalid  = s_rvalid[j];

        // Requests seen by slave j, one bit per master
        for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_req
            assign arb_req[j][i] = request[i] && target[i][j];
        end

        axil_slave_arbiter u_arb (
            .aclk     (aclk),
            .rst      (rst),
            .requests (arb_req[j]),
            .slave    (s_bus[j]),
            .grant    (arb_grant[j])
        );
    end

    axil_read_switch u_switch (
        .grants  (arb_grant),
        .masters (routed_bus),
        .slaves  (s_bus)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic aclk,
    output logic rst
);

    // 4 ns period
    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // Three rising edges in reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (3) @(negedge aclk);
        rst = 1'b0;
    end

endmodule

// ==== verification/tb_axil_read_xbar.sv ====
`timescale 1ns/1ps

module tb_axil_read_xbar;

    import axil_pkg::*;
    import xbar_cfg_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    // Slave models return address XOR tag
    localparam data_t TAG [NUM_SLAVES] = '{32'ha5a5_0000, 32'h5a5a_0000};

    logic   aclk;
    logic   rst;
    integer seed = 32'h556e_86a9;

    addr_t m_araddr  [NUM_MASTERS];
    logic  m_arvalid [NUM_MASTERS];
    logic  m_arready [NUM_MASTERS];
    data_t m_rdata   [NUM_MASTERS];
    resp_t m_rresp   [NUM_MASTERS];
    logic  m_rvalid  [NUM_MASTERS];
    logic  m_rready  [NUM_MASTERS];
    addr_t s_araddr  [NUM_SLAVES];
    logic  s_arvalid [NUM_SLAVES];
    logic  s_arready [NUM_SLAVES];
    data_t s_rdata   [NUM_SLAVES];
    resp_t s_rresp   [NUM_SLAVES];
    logic  s_rvalid  [NUM_SLAVES];
    logic  s_rready  [NUM_SLAVES];

    tb_clock_gen u_clk (
        .aclk (aclk),
        .rst  (rst)
    );

    axil_read_xbar u_dut (
        .aclk      (aclk),
        .rst       (rst),
        .m_araddr  (m_araddr),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_rdata   (m_rdata),
        .m_rresp   (m_rresp),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////////////////////////////////////////

    function automatic data_t expected_data(input addr_t a);
        data_t d;
        d = '0;
        for (int j = 0; j < NUM_SLAVES; j++) begin
            if (a >= SLAVE_BASE[j] && (a - SLAVE_BASE[j]) < SLAVE_SIZE[j]) begin
                d = a ^ TAG[j];
            end
        end
        return d;
    endfunction

    function automatic resp_t expected_resp(input addr_t a);
        resp_t r;
        r = DECERR;
        for (int j = 0; j < NUM_SLAVES; j++) begin
            if (a >= SLAVE_BASE[j] && (a - SLAVE_BASE[j]) < SLAVE_SIZE[j]) begin
                r = OKAY;
            end
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped on a timeout");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus models
    ////////////////////////////////////////////////////////////////////////////

    // One read from master i, optionally with random RREADY stalls
    task automatic read(input int i, input addr_t addr, output data_t data,
                        output resp_t resp, input logic stall);
        int    t;
        logic  stalled;
        logic  done;
        data_t held_data;
        resp_t held_resp;
        @(negedge aclk);
        m_araddr[i]  = addr;
        m_arvalid[i] = 1'b1;
        t = 0;
        do begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT_CYCLES) report_timeout("master AR handshake");
        end while (!m_arready[i]);
        @(negedge aclk);
        m_arvalid[i] = 1'b0;
        stalled = 1'b0;
        done    = 1'b0;
        t = 0;
        while (!done) begin
            m_rready[i] = stall ? (($random(seed) & 1) != 0) : 1'b1;
            @(posedge aclk);
            // A stalled response must not move
            if (stalled) begin
                check("m_rvalid", 32'(m_rvalid[i]), 32'd1);
                check("m_rdata", m_rdata[i], held_data);
                check("m_rresp", 32'(m_rresp[i]), 32'(held_resp));
            end
            stalled   = m_rvalid[i] && !m_rready[i];
            held_data = m_rdata[i];
            held_resp = m_rresp[i];
            done      = m_rvalid[i] && m_rready[i];
            t++;
            if (t > TIMEOUT_CYCLES) report_timeout("master R handshake");
            @(negedge aclk);
        end
        data = held_data;
        resp = held_resp;
        m_rready[i] = 1'b0;
    endtask

    // Slave j with random ARREADY and RVALID delays
    task automatic slave_model(input int j);
        int    delay;
        int    t;
        addr_t addr;
        forever begin
            @(posedge aclk);
            if (s_arvalid[j]) begin
                delay = $random(seed) & 3;
                repeat (delay) @(posedge aclk);
                @(negedge aclk);
                s_arready[j] = 1'b1;
                @(posedge aclk);
                addr = s_araddr[j];
                @(negedge aclk);
                s_arready[j] = 1'b0;
                delay = $random(seed) & 3;
                repeat (delay) @(negedge aclk);
                s_rdata[j]  = addr ^ TAG[j];
                s_rresp[j]  = OKAY;
                s_rvalid[j] = 1'b1;
                t = 0;
                do begin
                    @(posedge aclk);
                    t++;
                    if (t > TIMEOUT_CYCLES) report_timeout("slave R handshake");
                end while (!s_rready[j]);
                @(negedge aclk);
                s_rvalid[j] = 1'b0;
            end
        end
    endtask

    task automatic wait_ar(input int j, output addr_t addr);
        int t;
        t = 0;
        do begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT_CYCLES) report_timeout("slave AR handshake");
        end while (!(s_arvalid[j] && s_arready[j]));
        addr = s_araddr[j];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int t;
        t = 0;
        do begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT_CYCLES) report_timeout("reset release");
        end while (rst);
        @(posedge aclk);
        check("m_arready", {30'b0, m_arready[1], m_arready[0]}, '0);
        check("m_rvalid", {30'b0, m_rvalid[1], m_rvalid[0]}, '0);
        check("s_arvalid", {30'b0, s_arvalid[1], s_arvalid[0]}, '0);
        check("s_rready", {30'b0, s_rready[1], s_rready[0]}, '0);
    endtask

    task automatic test_single_reads();
        addr_t a;
        addr_t seen;
        data_t d;
        resp_t r;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            for (int j = 0; j < NUM_SLAVES; j++) begin
                a = SLAVE_BASE[j] + 32'h40 + i * 4;
                fork
                    read(i, a, d, r, 1'b0);
                    wait_ar(j, seen);
                join
                check("s_araddr", seen, a);
                check("m_rdata", d, expected_data(a));
                check("m_rresp", 32'(r), 32'(expected_resp(a)));
            end
        end
    endtask

    task automatic test_decode_error();
        data_t d;
        resp_t r;
        logic  done;
        int    t;
        done = 1'b0;
        t    = 0;
        fork
            begin
                read(1, 32'h8000_0010, d, r, 1'b0);
                done = 1'b1;
            end
            while (!done) begin
                @(posedge aclk);
                check("s_arvalid", {30'b0, s_arvalid[1], s_arvalid[0]}, '0);
                t++;
                if (t > TIMEOUT_CYCLES) report_timeout("decode error read");
            end
        join
        check("m_rdata", d, '0);
        check("m_rresp", 32'(r), 32'(DECERR));
    endtask

    // Master 0 must win slave 0 and master 1 follows after its R handshake
    task automatic test_contention();
        addr_t a0;
        addr_t a1;
        addr_t first;
        addr_t second;
        data_t d0;
        data_t d1;
        resp_t r0;
        resp_t r1;
        logic  m0_done;
        a0 = SLAVE_BASE[0] + 32'h100;
        a1 = SLAVE_BASE[0] + 32'h204;
        m0_done = 1'b0;
        fork
            begin
                read(0, a0, d0, r0, 1'b0);
                m0_done = 1'b1;
            end
            read(1, a1, d1, r1, 1'b0);
            begin
                wait_ar(0, first);
                check("s_araddr", first, a0);
                wait_ar(0, second);
                check("m0 R done before second AR", 32'(m0_done), 32'd1);
                check("s_araddr", second, a1);
            end
        join
        check("m_rdata", d0, expected_data(a0));
        check("m_rdata", d1, expected_data(a1));
        check("m_rresp", 32'(r0), 32'(OKAY));
        check("m_rresp", 32'(r1), 32'(OKAY));
    endtask

    task automatic random_reads(input int i);
        addr_t a;
        data_t d;
        resp_t r;
        for (int n = 0; n < 20; n++) begin
            a = $random(seed) & 32'h0000_1ffc;
            read(i, a, d, r, 1'b1);
            check("m_rdata", d, expected_data(a));
            check("m_rresp", 32'(r), 32'(expected_resp(a)));
        end
    endtask

    task automatic test_random_traffic();
        fork
            random_reads(0);
            random_reads(1);
        join
    endtask

    initial begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            m_araddr[i]  = '0;
            m_arvalid[i] = 1'b0;
            m_rready[i]  = 1'b0;
        end
        for (int j = 0; j < NUM_SLAVES; j++) begin
            s_arready[j] = 1'b0;
            s_rdata[j]   = '0;
            s_rresp[j]   = OKAY;
            s_rvalid[j]  = 1'b0;
        end
        fork
            slave_model(0);
            slave_model(1);
        join_none
        test_reset_state();
        test_single_reads();
        test_decode_error();
        test_contention();
        test_random_traffic();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== axil_read_xbar.f ====
rtl/axil_pkg.sv
rtl/xbar_cfg_pkg.sv
rtl/axil_read_if.sv
rtl/axil_master_port.sv
rtl/axil_slave_arbiter.sv
rtl/axil_read_switch.sv
rtl/axil_read_xbar.sv
verification/tb_clock_gen.sv
verification/tb_axil_read_xbar.sv

// ==== Makefile ====
BIN  := obj_dir/Vtb_axil_read_xbar
SRCS := $(shell cat axil_read_xbar.f)

.PHONY: all run clean

all: $(BIN)

$(BIN): axil_read_xbar.f $(SRCS)
	verilator --binary --timescale 1ns/1ps --top-module tb_axil_read_xbar \
		--Mdir obj_dir -o Vtb_axil_read_xbar -f axil_read_xbar.f

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
